// File: hdl/bus_pkg.sv
package bus_pkg;

  // bus geometry
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // byte address
  typedef logic [ADDR_W-1:0] addr_t;

  // one bus word
  typedef logic [DATA_W-1:0] data_t;

  // one enable per byte lane
  typedef logic [STRB_W-1:0] strb_t;

  // load/store request, also what every target sees
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t wstrb;
    logic  write;
  } bus_req_t;

  // single-beat response
  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

endpackage

// File: hdl/map_pkg.sv
package map_pkg;

  // memory window
  localparam bus_pkg::addr_t MEM_BASE = 32'h8000_0000;
  localparam int MEM_WORDS = 256;
  localparam bus_pkg::addr_t MEM_END = MEM_BASE + bus_pkg::addr_t'(MEM_WORDS * 4);

  // single-register devices
  localparam bus_pkg::addr_t SERIAL_ADDR = 32'h1000_0000;
  localparam bus_pkg::addr_t CLINT_LO_ADDR = 32'h0200_bff8;
  localparam bus_pkg::addr_t CLINT_HI_ADDR = 32'h0200_bffc;

  // device timing in cycles
  localparam int MEM_LATENCY = 2;
  localparam int SERIAL_BUSY_CYCLES = 4;

  typedef logic [$clog2(MEM_WORDS)-1:0] mem_idx_t;
  typedef logic [$clog2(MEM_LATENCY+1)-1:0] mem_cnt_t;
  typedef logic [$clog2(SERIAL_BUSY_CYCLES+1)-1:0] busy_cnt_t;
  typedef logic [63:0] mtime_t;

endpackage

// File: hdl/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::addr_t    ifu_addr_i,
  input  logic              ifu_valid_i,
  output logic              ifu_ready_o,
  output bus_pkg::bus_rsp_t ifu_rsp_o,
  output logic              ifu_rsp_valid_o,
  input  bus_pkg::bus_req_t lsu_req_i,
  input  logic              lsu_valid_i,
  output logic              lsu_ready_o,
  output bus_pkg::bus_rsp_t lsu_rsp_o,
  output logic              lsu_rsp_valid_o,
  output bus_pkg::bus_req_t mem_req_o,
  output logic              mem_valid_o,
  input  logic              mem_ready_i,
  input  bus_pkg::bus_rsp_t mem_rsp_i,
  input  logic              mem_rsp_valid_i,
  output bus_pkg::bus_req_t serial_req_o,
  output logic              serial_valid_o,
  input  logic              serial_ready_i,
  input  bus_pkg::bus_rsp_t serial_rsp_i,
  input  logic              serial_rsp_valid_i,
  output bus_pkg::bus_req_t clint_req_o,
  output logic              clint_valid_o,
  input  logic              clint_ready_i,
  input  bus_pkg::bus_rsp_t clint_rsp_i,
  input  logic              clint_rsp_valid_i
);
  import bus_pkg::*;
  import map_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_WAIT_RSP, ST_ERR_RSP} state_t;
  typedef enum logic {OWN_IFU, OWN_LSU} owner_t;
  typedef enum logic [1:0] {TGT_MEM, TGT_SERIAL, TGT_CLINT, TGT_ERR} target_t;

  state_t   state;
  owner_t   owner_q;
  target_t  tgt_q;
  target_t  dec_tgt;
  bus_req_t ifu_req;
  bus_req_t sel_req;
  logic     idle;
  logic     req_valid;
  logic     tgt_ready;
  bus_rsp_t rsp;
  logic     rsp_valid;

  // serial is write only, timer is read only
  function automatic target_t decode(bus_req_t r);
    target_t t;
    if (r.addr >= MEM_BASE && r.addr < MEM_END)
      t = TGT_MEM;
    else if (r.addr == SERIAL_ADDR && r.write)
      t = TGT_SERIAL;
    else if ((r.addr == CLINT_LO_ADDR || r.addr == CLINT_HI_ADDR) && !r.write)
      t = TGT_CLINT;
    else
      t = TGT_ERR;
    return t;
  endfunction

  // fetch is always a plain read
  assign ifu_req = '{addr: ifu_addr_i, wdata: '0, wstrb: '0, write: 1'b0};

  // load/store has priority
  assign sel_req   = lsu_valid_i ? lsu_req_i : ifu_req;
  assign dec_tgt   = decode(sel_req);
  assign idle      = (state == ST_IDLE);
  assign req_valid = idle && (lsu_valid_i || ifu_valid_i);

  always_comb
  begin
    case (dec_tgt)
      TGT_MEM:    tgt_ready = mem_ready_i;
      TGT_SERIAL: tgt_ready = serial_ready_i;
      TGT_CLINT:  tgt_ready = clint_ready_i;
      default:    tgt_ready = 1'b1;
    endcase
  end

  assign lsu_ready_o = idle && lsu_valid_i && tgt_ready;
  assign ifu_ready_o = idle && ifu_valid_i && !lsu_valid_i && tgt_ready;

  // same request to every target, only one valid
  assign mem_req_o      = sel_req;
  assign serial_req_o   = sel_req;
  assign clint_req_o    = sel_req;
  assign mem_valid_o    = req_valid && (dec_tgt == TGT_MEM);
  assign serial_valid_o = req_valid && (dec_tgt == TGT_SERIAL);
  assign clint_valid_o  = req_valid && (dec_tgt == TGT_CLINT);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state   <= ST_IDLE;
      owner_q <= OWN_IFU;
      tgt_q   <= TGT_ERR;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (req_valid && tgt_ready)
          begin
            owner_q <= lsu_valid_i ? OWN_LSU : OWN_IFU;
            tgt_q   <= dec_tgt;
            state   <= (dec_tgt == TGT_ERR) ? ST_ERR_RSP : ST_WAIT_RSP;
          end
        end
        ST_WAIT_RSP:
        begin
          if (rsp_valid)
            state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // pick the owner's response, error beats come from here
  always_comb
  begin
    case (tgt_q)
      TGT_MEM:
      begin
        rsp       = mem_rsp_i;
        rsp_valid = (state == ST_WAIT_RSP) && mem_rsp_valid_i;
      end
      TGT_SERIAL:
      begin
        rsp       = serial_rsp_i;
        rsp_valid = (state == ST_WAIT_RSP) && serial_rsp_valid_i;
      end
      TGT_CLINT:
      begin
        rsp       = clint_rsp_i;
        rsp_valid = (state == ST_WAIT_RSP) && clint_rsp_valid_i;
      end
      default:
      begin
        rsp       = '{rdata: '0, err: 1'b1};
        rsp_valid = (state == ST_ERR_RSP);
      end
    endcase
  end

  assign ifu_rsp_o       = rsp;
  assign lsu_rsp_o       = rsp;
  assign ifu_rsp_valid_o = rsp_valid && (owner_q == OWN_IFU);
  assign lsu_rsp_valid_o = rsp_valid && (owner_q == OWN_LSU);

endmodule

// File: hdl/mem_target.sv
`timescale 1ns/10ps

module mem_target (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req_i,
  input  logic              valid_i,
  output logic              ready_o,
  output bus_pkg::bus_rsp_t rsp_o,
  output logic              rsp_valid_o
);
  import bus_pkg::*;
  import map_pkg::*;

  data_t    mem [MEM_WORDS];
  data_t    rdata_q;
  mem_cnt_t cnt;
  mem_idx_t idx;
  logic     accept;

  // word offset inside the window
  assign idx    = mem_idx_t'((req_i.addr - MEM_BASE) >> 2);
  assign accept = valid_i && ready_o;

  // busy until the response has gone out
  assign ready_o = (cnt == '0);

  always_ff @(posedge clk)
  begin
    if (rst)
      cnt <= '0;
    else if (accept)
      cnt <= mem_cnt_t'(MEM_LATENCY);
    else if (cnt != '0)
      cnt <= cnt - 1'b1;
  end

  // array and read data
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      if (req_i.write)
      begin
        rdata_q <= '0;
        for (int b = 0; b < STRB_W; b++)
        begin
          if (req_i.wstrb[b])
            mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
      else
        rdata_q <= mem[idx];
    end
  end

  // last count before idle
  assign rsp_valid_o = (cnt == mem_cnt_t'(1));
  assign rsp_o       = '{rdata: rdata_q, err: 1'b0};

endmodule

// File: hdl/serial_target.sv
`timescale 1ns/10ps

module serial_target (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req_i,
  input  logic              valid_i,
  output logic              ready_o,
  output bus_pkg::bus_rsp_t rsp_o,
  output logic              rsp_valid_o,
  output logic [7:0]        byte_o,
  output logic              byte_valid_o
);
  import map_pkg::*;

  busy_cnt_t  busy;
  logic       pulse_q;
  logic [7:0] byte_q;
  logic       accept;

  assign accept  = valid_i && ready_o;
  assign ready_o = (busy == '0);

  // transmit time after every byte
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy    <= '0;
      pulse_q <= 1'b0;
    end
    else
    begin
      pulse_q <= accept;
      if (accept)
        busy <= busy_cnt_t'(SERIAL_BUSY_CYCLES);
      else if (busy != '0)
        busy <= busy - 1'b1;
    end
  end

  // only the low lane goes out
  always_ff @(posedge clk)
  begin
    if (accept)
      byte_q <= req_i.wdata[7:0];
  end

  assign byte_o       = byte_q;
  assign byte_valid_o = pulse_q;
  assign rsp_valid_o  = pulse_q;
  assign rsp_o        = '{rdata: '0, err: 1'b0};

endmodule

// File: hdl/clint_timer.sv
`timescale 1ns/10ps

module clint_timer (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::bus_req_t req_i,
  input  logic              valid_i,
  output logic              ready_o,
  output bus_pkg::bus_rsp_t rsp_o,
  output logic              rsp_valid_o
);
  import bus_pkg::*;
  import map_pkg::*;

  mtime_t mtime;
  data_t  rdata_q;
  logic   rsp_valid_q;

  // never stalls
  assign ready_o = 1'b1;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mtime       <= '0;
      rsp_valid_q <= 1'b0;
    end
    else
    begin
      mtime       <= mtime + 1'b1;
      rsp_valid_q <= valid_i;
    end
  end

  // bit 2 picks the upper word
  always_ff @(posedge clk)
  begin
    if (valid_i)
      rdata_q <= req_i.addr[2] ? mtime[63:32] : mtime[31:0];
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = '{rdata: rdata_q, err: 1'b0};

endmodule

// File: hdl/soc_bus_top.sv
`timescale 1ns/10ps

module soc_bus_top (
  input  logic              clk,
  input  logic              rst,
  input  bus_pkg::addr_t    ifu_addr_i,
  input  logic              ifu_valid_i,
  output logic              ifu_ready_o,
  output bus_pkg::bus_rsp_t ifu_rsp_o,
  output logic              ifu_rsp_valid_o,
  input  bus_pkg::bus_req_t lsu_req_i,
  input  logic              lsu_valid_i,
  output logic              lsu_ready_o,
  output bus_pkg::bus_rsp_t lsu_rsp_o,
  output logic              lsu_rsp_valid_o,
  output logic [7:0]        serial_byte_o,
  output logic              serial_byte_valid_o
);
  import bus_pkg::*;

  bus_req_t mem_req, serial_req, clint_req;
  bus_rsp_t mem_rsp, serial_rsp, clint_rsp;
  logic     mem_valid, serial_valid, clint_valid;
  logic     mem_ready, serial_ready, clint_ready;
  logic     mem_rsp_valid, serial_rsp_valid, clint_rsp_valid;

  bus_arbiter u_arbiter (
    .clk                (clk),
    .rst                (rst),
    .ifu_addr_i         (ifu_addr_i),
    .ifu_valid_i        (ifu_valid_i),
    .ifu_ready_o        (ifu_ready_o),
    .ifu_rsp_o          (ifu_rsp_o),
    .ifu_rsp_valid_o    (ifu_rsp_valid_o),
    .lsu_req_i          (lsu_req_i),
    .lsu_valid_i        (lsu_valid_i),
    .lsu_ready_o        (lsu_ready_o),
    .lsu_rsp_o          (lsu_rsp_o),
    .lsu_rsp_valid_o    (lsu_rsp_valid_o),
    .mem_req_o          (mem_req),
    .mem_valid_o        (mem_valid),
    .mem_ready_i        (mem_ready),
    .mem_rsp_i          (mem_rsp),
    .mem_rsp_valid_i    (mem_rsp_valid),
    .serial_req_o       (serial_req),
    .serial_valid_o     (serial_valid),
    .serial_ready_i     (serial_ready),
    .serial_rsp_i       (serial_rsp),
    .serial_rsp_valid_i (serial_rsp_valid),
    .clint_req_o        (clint_req),
    .clint_valid_o      (clint_valid),
    .clint_ready_i      (clint_ready),
    .clint_rsp_i        (clint_rsp),
    .clint_rsp_valid_i  (clint_rsp_valid)
  );

  mem_target u_mem (
    .clk         (clk),
    .rst         (rst),
    .req_i       (mem_req),
    .valid_i     (mem_valid),
    .ready_o     (mem_ready),
    .rsp_o       (mem_rsp),
    .rsp_valid_o (mem_rsp_valid)
  );

  // byte strobe leaves the top level directly
  serial_target u_serial (
    .clk          (clk),
    .rst          (rst),
    .req_i        (serial_req),
    .valid_i      (serial_valid),
    .ready_o      (serial_ready),
    .rsp_o        (serial_rsp),
    .rsp_valid_o  (serial_rsp_valid),
    .byte_o       (serial_byte_o),
    .byte_valid_o (serial_byte_valid_o)
  );

  clint_timer u_clint (
    .clk         (clk),
    .rst         (rst),
    .req_i       (clint_req),
    .valid_i     (clint_valid),
    .ready_o     (clint_ready),
    .rsp_o       (clint_rsp),
    .rsp_valid_o (clint_rsp_valid)
  );

endmodule

// File: sim/soc_bus_assert.sv
`timescale 1ns/10ps

module soc_bus_assert (
  input logic clk,
  input logic rst,
  input logic ifu_valid_i,
  input logic ifu_ready_i,
  input logic ifu_rsp_valid_i,
  input logic lsu_valid_i,
  input logic lsu_ready_i,
  input logic lsu_rsp_valid_i
);
  logic accept;
  logic rsp;
  logic pending;
  logic lsu_owns;

  assign accept = (ifu_valid_i && ifu_ready_i) || (lsu_valid_i && lsu_ready_i);
  assign rsp    = ifu_rsp_valid_i || lsu_rsp_valid_i;

  // open transaction between acceptance and its response
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pending  <= 1'b0;
      lsu_owns <= 1'b0;
    end
    else if (accept)
    begin
      pending  <= 1'b1;
      lsu_owns <= lsu_valid_i && lsu_ready_i;
    end
    else if (rsp)
      pending <= 1'b0;
  end

  // the response goes back to whoever won the open transaction
  ifu_rsp_owner: assert property (@(posedge clk) disable iff (rst)
    ifu_rsp_valid_i |-> pending && !lsu_owns)
    else $error("fetch got a response without an open fetch request");

  lsu_rsp_owner: assert property (@(posedge clk) disable iff (rst)
    lsu_rsp_valid_i |-> pending && lsu_owns)
    else $error("load/store got a response without an open load/store request");

  ifu_ready_idle: assert property (@(posedge clk) disable iff (rst) ifu_ready_i |-> !pending)
    else $error("fetch ready high while a transaction is still open");

  lsu_ready_idle: assert property (@(posedge clk) disable iff (rst) lsu_ready_i |-> !pending)
    else $error("load/store ready high while a transaction is still open");

  accept_after_rsp: assert property (@(posedge clk) disable iff (rst) accept |-> !pending)
    else $error("new request accepted before the previous response");

endmodule

bind bus_arbiter soc_bus_assert u_assert (
  .clk             (clk),
  .rst             (rst),
  .ifu_valid_i     (ifu_valid_i),
  .ifu_ready_i     (ifu_ready_o),
  .ifu_rsp_valid_i (ifu_rsp_valid_o),
  .lsu_valid_i     (lsu_valid_i),
  .lsu_ready_i     (lsu_ready_o),
  .lsu_rsp_valid_i (lsu_rsp_valid_o)
);

// File: sim/tb_soc_bus.sv
`timescale 1ns/10ps

module tb_soc_bus;
  import bus_pkg::*;
  import map_pkg::*;

  typedef enum logic [1:0] {M_LSU, M_IFU, M_BOTH} master_e;
  typedef enum logic [1:0] {CK_MEM, CK_FIXED, CK_SERIAL, CK_TIME} check_e;

  // one table row, exp is used by the fixed and serial kinds
  typedef struct {
    master_e  who;
    bus_req_t req;
    bus_rsp_t exp;
    check_e   ck;
    int       gap;
  } entry_t;

  logic       clk;
  logic       rst;
  addr_t      ifu_addr;
  logic       ifu_valid;
  logic       ifu_ready;
  bus_rsp_t   ifu_rsp;
  logic       ifu_rsp_valid;
  bus_req_t   lsu_req;
  logic       lsu_valid;
  logic       lsu_ready;
  bus_rsp_t   lsu_rsp;
  logic       lsu_rsp_valid;
  logic [7:0] serial_byte;
  logic       serial_byte_valid;

  entry_t      tbl[$];
  data_t       ref_mem [MEM_WORDS];
  logic [15:0] lfsr = 16'd16;
  int          cycle = 0;
  int          timeout_limit = 0;
  int          checks = 0;
  int          rsp_errs = 0;
  int          byte_errs = 0;
  int          lat_errs = 0;
  int          other_errs = 0;
  logic        have_lo = 1'b0;
  data_t       lo_first;
  int          lo_acc;
  logic        have_ser = 1'b0;
  int          ser_acc;

  soc_bus_top dut (
    .clk                 (clk),
    .rst                 (rst),
    .ifu_addr_i          (ifu_addr),
    .ifu_valid_i         (ifu_valid),
    .ifu_ready_o         (ifu_ready),
    .ifu_rsp_o           (ifu_rsp),
    .ifu_rsp_valid_o     (ifu_rsp_valid),
    .lsu_req_i           (lsu_req),
    .lsu_valid_i         (lsu_valid),
    .lsu_ready_o         (lsu_ready),
    .lsu_rsp_o           (lsu_rsp),
    .lsu_rsp_valid_o     (lsu_rsp_valid),
    .serial_byte_o       (serial_byte),
    .serial_byte_valid_o (serial_byte_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (timeout_limit > 0 && cycle >= timeout_limit)
    begin
      $display("timeout after %0d cycles, the bus stopped answering", cycle);
      $display("test failed");
      $finish;
    end
  end

  // taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    repeat (n)
    begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic check_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
    checks++;
    if (got !== exp)
    begin
      rsp_errs++;
      $display("** Error at %0t: %s rdata=%h err=%b, expected rdata=%h err=%b",
               $time, name, got.rdata, got.err, exp.rdata, exp.err);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp)
    begin
      byte_errs++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    checks++;
    if (got != exp)
    begin
      lat_errs++;
      $display("** Error at %0t: %s latency = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_fault(input string what);
    other_errs++;
    $display("at %0t: %s", $time, what);
  endtask

  task automatic expect_quiet(input string when);
    checks++;
    if (ifu_rsp_valid !== 1'b0 || lsu_rsp_valid !== 1'b0 || serial_byte_valid !== 1'b0)
      report_fault({"a response or serial valid is not low ", when});
  endtask

  task automatic add_entry(input master_e who, input addr_t a, input data_t d, input strb_t s,
                           input logic w, input check_e ck, input logic err, input int gap);
    entry_t e;
    e.who = who;
    e.req = '{addr: a, wdata: d, wstrb: s, write: w};
    e.exp = '{rdata: '0, err: err};
    e.ck  = ck;
    e.gap = gap;
    tbl.push_back(e);
  endtask

  // valid is already driven, returns on the response cycle
  task automatic run_transfer(input master_e who, input bus_req_t r, input check_e ck,
                              input bus_rsp_t fixed_exp);
    int       acc;
    int       lat;
    int       idx;
    bus_rsp_t exp;
    bus_rsp_t got;
    logic     got_valid;
    logic     record_only;
    string    tag;
    tag         = (who == M_LSU) ? "lsu_rsp_o" : "ifu_rsp_o";
    exp         = fixed_exp;
    record_only = 1'b0;
    @(negedge clk);
    while (!((who == M_LSU) ? lsu_ready : ifu_ready))
      @(negedge clk);
    acc = cycle;
    if (who == M_LSU && ifu_ready)
      report_fault("fetch granted in the same cycle as load/store");
    case (ck)
      CK_MEM:
      begin
        idx = int'((r.addr - MEM_BASE) >> 2);
        if (r.write)
        begin
          for (int b = 0; b < STRB_W; b++)
          begin
            if (r.wstrb[b])
              ref_mem[idx][8*b +: 8] = r.wdata[8*b +: 8];
          end
          // write responses carry no data
          exp = '{rdata: '0, err: 1'b0};
        end
        else
          exp = '{rdata: ref_mem[idx], err: 1'b0};
      end
      CK_SERIAL:
      begin
        if (have_ser && acc - ser_acc <= SERIAL_BUSY_CYCLES)
          report_fault("serial write accepted while the port was still busy");
        have_ser = 1'b1;
        ser_acc  = acc;
      end
      CK_TIME:
      begin
        // counter advances once per cycle
        if (have_lo)
          exp = '{rdata: lo_first + data_t'(acc - lo_acc), err: 1'b0};
        else
          record_only = 1'b1;
      end
      default: ;
    endcase
    @(posedge clk);
    if (who == M_LSU)
      lsu_valid <= 1'b0;
    else
      ifu_valid <= 1'b0;
    lat       = 0;
    got_valid = 1'b0;
    while (!got_valid)
    begin
      @(negedge clk);
      lat++;
      got_valid = (who == M_LSU) ? lsu_rsp_valid : ifu_rsp_valid;
      if ((who == M_LSU) ? ifu_rsp_valid : lsu_rsp_valid)
        report_fault("response went to the master that does not own the bus");
      if (ck != CK_SERIAL && serial_byte_valid)
        report_fault("serial byte appeared without a serial write");
    end
    got = (who == M_LSU) ? lsu_rsp : ifu_rsp;
    check_latency(tag, lat, (ck == CK_MEM) ? MEM_LATENCY : 1);
    if (record_only)
    begin
      have_lo  = 1'b1;
      lo_first = got.rdata;
      lo_acc   = acc;
      if (got.err !== 1'b0)
        report_fault("timer read returned an error");
    end
    else
      check_rsp(tag, got, exp);
    if (ck == CK_SERIAL)
    begin
      if (serial_byte_valid !== 1'b1)
        report_fault("no serial byte came with the serial response");
      else
        check_byte("serial_byte_o", serial_byte, r.wdata[7:0]);
    end
  endtask

  task automatic apply_entry(input entry_t e);
    int    gap;
    int    k;
    addr_t fetch_addr;
    @(posedge clk);
    gap = e.gap;
    if (gap < 0)
      take_bits(2, gap);
    repeat (gap) @(posedge clk);
    case (e.who)
      M_LSU:
      begin
        lsu_req   <= e.req;
        lsu_valid <= 1'b1;
        run_transfer(M_LSU, e.req, e.ck, e.exp);
      end
      M_IFU:
      begin
        ifu_addr  <= e.req.addr;
        ifu_valid <= 1'b1;
        run_transfer(M_IFU, e.req, e.ck, e.exp);
      end
      default:
      begin
        // fetch word picked from the fully written range
        take_bits(3, k);
        fetch_addr = MEM_BASE + addr_t'(4 * k);
        lsu_req   <= e.req;
        lsu_valid <= 1'b1;
        ifu_addr  <= fetch_addr;
        ifu_valid <= 1'b1;
        run_transfer(M_LSU, e.req, e.ck, e.exp);
        run_transfer(M_IFU, '{addr: fetch_addr, wdata: '0, wstrb: '0, write: 1'b0},
                     CK_MEM, '{rdata: '0, err: 1'b0});
      end
    endcase
  endtask

  task automatic fill_table();
    // whole words first, so no read sees unwritten bytes
    add_entry(M_LSU, MEM_BASE + 32'h00, 32'h1122_3344, 4'hf, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h04, 32'ha5a5_0f0f, 4'hf, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h08, 32'hdead_beef, 4'hf, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h0c, 32'h0123_4567, 4'hf, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h10, 32'hcafe_f00d, 4'hf, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h14, 32'h7654_3210, 4'hf, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h18, 32'h0f1e_2d3c, 4'hf, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h1c, 32'h8899_aabb, 4'hf, 1'b1, CK_MEM, 1'b0, -1);
    // partial strobes, then read back
    add_entry(M_LSU, MEM_BASE + 32'h04, 32'hffff_0000, 4'h3, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h08, 32'h5566_7788, 4'ha, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h0c, 32'h00cc_0000, 4'h4, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h1c, 32'h1234_5678, 4'h8, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h04, 32'h0, 4'h0, 1'b0, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h08, 32'h0, 4'h0, 1'b0, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h0c, 32'h0, 4'h0, 1'b0, CK_MEM, 1'b0, -1);
    add_entry(M_LSU, MEM_BASE + 32'h1c, 32'h0, 4'h0, 1'b0, CK_MEM, 1'b0, -1);
    add_entry(M_IFU, MEM_BASE + 32'h00, 32'h0, 4'h0, 1'b0, CK_MEM, 1'b0, -1);
    add_entry(M_IFU, MEM_BASE + 32'h14, 32'h0, 4'h0, 1'b0, CK_MEM, 1'b0, -1);
    // both masters in the same cycle
    add_entry(M_BOTH, MEM_BASE + 32'h18, 32'h9900_0011, 4'h9, 1'b1, CK_MEM, 1'b0, -1);
    add_entry(M_BOTH, MEM_BASE + 32'h10, 32'h0, 4'h0, 1'b0, CK_MEM, 1'b0, -1);
    // second byte queued straight behind the first
    add_entry(M_LSU, SERIAL_ADDR, 32'h0000_0041, 4'h1, 1'b1, CK_SERIAL, 1'b0, -1);
    add_entry(M_LSU, SERIAL_ADDR, 32'h0000_1242, 4'h1, 1'b1, CK_SERIAL, 1'b0, 0);
    add_entry(M_LSU, CLINT_LO_ADDR, 32'h0, 4'h0, 1'b0, CK_TIME, 1'b0, -1);
    add_entry(M_LSU, CLINT_LO_ADDR, 32'h0, 4'h0, 1'b0, CK_TIME, 1'b0, 3);
    add_entry(M_IFU, CLINT_HI_ADDR, 32'h0, 4'h0, 1'b0, CK_FIXED, 1'b0, -1);
    // decode errors
    add_entry(M_LSU, 32'h2000_0000, 32'h0, 4'h0, 1'b0, CK_FIXED, 1'b1, -1);
    add_entry(M_IFU, SERIAL_ADDR, 32'h0, 4'h0, 1'b0, CK_FIXED, 1'b1, -1);
    add_entry(M_LSU, CLINT_LO_ADDR, 32'h0000_0055, 4'hf, 1'b1, CK_FIXED, 1'b1, -1);
    add_entry(M_LSU, MEM_END, 32'h0, 4'h0, 1'b0, CK_FIXED, 1'b1, -1);
    add_entry(M_LSU, MEM_BASE + 32'h18, 32'h0, 4'h0, 1'b0, CK_MEM, 1'b0, -1);
  endtask

  initial
  begin
    int errs;
    rst       = 1'b1;
    ifu_addr  = '0;
    ifu_valid = 1'b0;
    lsu_req   = '0;
    lsu_valid = 1'b0;
    fill_table();
    timeout_limit = tbl.size() * 20 + 100;
    @(posedge clk);
    @(negedge clk);
    expect_quiet("during reset");
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    expect_quiet("right after reset");
    foreach (tbl[i])
      apply_entry(tbl[i]);
    repeat (4) @(posedge clk);
    errs = rsp_errs + byte_errs + lat_errs + other_errs;
    $display("checks %0d, errors %0d (response %0d, byte %0d, latency %0d, other %0d)",
             checks, errs, rsp_errs, byte_errs, lat_errs, other_errs);
    if (errs == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: filelist.f
hdl/bus_pkg.sv
hdl/map_pkg.sv
hdl/bus_arbiter.sv
hdl/mem_target.sv
hdl/serial_target.sv
hdl/clint_timer.sv
hdl/soc_bus_top.sv
sim/soc_bus_assert.sv
sim/tb_soc_bus.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_soc_bus
FILELIST  := filelist.f
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
